/* hdl/cl_consts.svh */
// Address map, depths and widths of the core-local peripheral block; include where needed
`ifndef CL_CONSTS_SVH
`define CL_CONSTS_SVH

// Bus widths
`define CL_ADDR_W 32
`define CL_ERR_BITS 2

// Interrupt sources
`define CL_NUM_IRQS 10
`define CL_NUM_TIMER_IRQS 2

// Tracker and log depths
`define CL_MAX_OUTSTANDING 2
`define CL_NUM_STORED_ERRS 8

// Peripheral address map
`define CL_PERIPH_BASE 32'h0020_0000
`define CL_INSTR_ERR_OFFSET 32'h0000_2000
`define CL_DATA_ERR_OFFSET 32'h0000_3000
`define CL_SHADOW_ERR_OFFSET 32'h0000_4000
`define CL_WINDOW_SIZE 32'h0000_1000

// Read value for unmapped addresses
`define CL_ERR_RDATA 32'hBADC_AB1E

`endif

/* hdl/cl_periph_pkg.sv */
// Bus structs and enums shared by the core-local peripheral RTL and its testbench
`include "cl_consts.svh"

package cl_periph_pkg;

  // Register bus request, valid held until ready
  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [`CL_ADDR_W-1:0] addr;
    logic [`CL_ADDR_W-1:0] wdata;
  } reg_req_t;

  // Register bus response
  typedef struct packed {
    logic                  ready;
    logic                  error;
    logic [`CL_ADDR_W-1:0] rdata;
  } reg_rsp_t;

  // Observed memory bus, all fields driven from outside
  typedef struct packed {
    logic                    req;
    logic                    gnt;
    logic [`CL_ADDR_W-1:0]   addr;
    logic                    rvalid;
    logic [`CL_ERR_BITS-1:0] err;
  } obi_mon_t;

  typedef struct packed {
    logic [`CL_ADDR_W-1:0]   addr;
    logic [`CL_ERR_BITS-1:0] err;
  } err_rec_t;

  // Word offsets inside an error window
  typedef enum logic [3:0] {
    ERR_ADDR   = 4'h0,
    ERR_CODE   = 4'h4,
    ERR_POP    = 4'h8,
    ERR_STATUS = 4'hC
  } err_reg_e;

  typedef enum logic [1:0] {
    SEL_INSTR  = 2'd0,
    SEL_DATA   = 2'd1,
    SEL_SHADOW = 2'd2,
    SEL_NONE   = 2'd3
  } periph_sel_e;

endpackage

/* hdl/regbus_demux.sv */
// Register bus decoder that routes requests to the three error logs and answers unmapped ones
`timescale 1ns/1ps
`include "cl_consts.svh"

module regbus_demux (
  input  cl_periph_pkg::reg_req_t       reg_req_i,
  output cl_periph_pkg::reg_rsp_t       reg_rsp_o,
  output cl_periph_pkg::reg_req_t [2:0] unit_req_o,
  input  cl_periph_pkg::reg_rsp_t [2:0] unit_rsp_i
);

  import cl_periph_pkg::*;

  periph_sel_e sel;
  logic [2:0]  hit;
  logic [2:0]  unit_valid;

  function automatic logic in_window(input logic [`CL_ADDR_W-1:0] addr,
                                     input logic [`CL_ADDR_W-1:0] offset);
    logic [`CL_ADDR_W-1:0] start_addr;
    start_addr = `CL_PERIPH_BASE + offset;
    return (addr >= start_addr) && (addr < start_addr + `CL_WINDOW_SIZE);
  endfunction

  always_comb begin
    hit[0] = in_window(reg_req_i.addr, `CL_INSTR_ERR_OFFSET);
    hit[1] = in_window(reg_req_i.addr, `CL_DATA_ERR_OFFSET);
    hit[2] = in_window(reg_req_i.addr, `CL_SHADOW_ERR_OFFSET);
    if (hit[0]) begin
      sel = SEL_INSTR;
    end else if (hit[1]) begin
      sel = SEL_DATA;
    end else if (hit[2]) begin
      sel = SEL_SHADOW;
    end else begin
      sel = SEL_NONE;
    end
  end

  // Address and data fan out to all units, only valid is steered
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      unit_valid[i]       = reg_req_i.valid && (sel == periph_sel_e'(i));
      unit_req_o[i]       = reg_req_i;
      unit_req_o[i].valid = unit_valid[i];
    end
  end

  always_comb begin
    case (sel)
      SEL_INSTR:  reg_rsp_o = unit_rsp_i[0];
      SEL_DATA:   reg_rsp_o = unit_rsp_i[1];
      SEL_SHADOW: reg_rsp_o = unit_rsp_i[2];
      default: begin
        // Former TCLS/CLIC windows land here too
        reg_rsp_o.ready = reg_req_i.valid;
        reg_rsp_o.error = 1'b1;
        reg_rsp_o.rdata = `CL_ERR_RDATA;
      end
    endcase
  end

  // Overlapping windows would be hidden by the priority decode
  always_comb begin
    assert ($onehot0(hit))
      else $error("regbus_demux: address falls in more than one unit window");
  end

endmodule

/* hdl/obi_txn_tracker.sv */
// Tracks granted memory bus addresses until their responses return and flags error responses
`timescale 1ns/1ps
`include "cl_consts.svh"

module obi_txn_tracker (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  cl_periph_pkg::obi_mon_t bus_i,
  output logic                    err_valid_o,
  output cl_periph_pkg::err_rec_t err_rec_o
);

  localparam int unsigned DEPTH = `CL_MAX_OUTSTANDING;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [`CL_ADDR_W-1:0] addr_q [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic                  push;
  logic                  pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = bus_i.req && bus_i.gnt;
  assign pop  = bus_i.rvalid && (count_q != '0);

  // Responses come back in order, so the head is always the matching address
  assign err_valid_o    = bus_i.rvalid && (bus_i.err != '0);
  assign err_rec_o.addr = addr_q[rd_ptr_q];
  assign err_rec_o.err  = bus_i.err;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      addr_q[wr_ptr_q] <= bus_i.addr;
    end
  end

  // Bus must respect the outstanding limit
  assert property (@(posedge clk_i) disable iff (reset_i)
    bus_i.rvalid |-> (count_q != '0))
    else $error("obi_txn_tracker: response without outstanding request");

  assert property (@(posedge clk_i) disable iff (reset_i)
    (push && (count_q == CNT_W'(DEPTH))) |-> bus_i.rvalid)
    else $error("obi_txn_tracker: grant beyond outstanding depth");

endmodule

/* hdl/bus_err_log.sv */
// Error record FIFO with interrupt and register access for one memory bus
`timescale 1ns/1ps
`include "cl_consts.svh"

module bus_err_log (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    err_valid_i,
  input  cl_periph_pkg::err_rec_t err_rec_i,
  input  cl_periph_pkg::reg_req_t reg_req_i,
  output cl_periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                    err_irq_o
);

  import cl_periph_pkg::*;

  localparam int unsigned DEPTH = `CL_NUM_STORED_ERRS;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  err_rec_t         fifo_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             ovf_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;
  err_reg_e         reg_sel;
  err_rec_t         head;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count_q == CNT_W'(DEPTH));
  assign empty   = (count_q == '0);
  assign reg_sel = err_reg_e'(reg_req_i.addr[3:0]);
  assign head    = fifo_q[rd_ptr_q];

  assign pop  = reg_req_i.valid && reg_req_i.write && (reg_sel == ERR_POP) && !empty;
  // When full, new records are dropped unless a pop frees a slot
  assign push = err_valid_i && (!full || pop);

  assign err_irq_o = !empty;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ovf_q    <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
      // Sticky until reset
      if (err_valid_i && !push) begin
        ovf_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= err_rec_i;
    end
  end

  // Register reads, writes other than pop have no effect
  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    case (reg_sel)
      ERR_ADDR: begin
        if (!empty) begin
          reg_rsp_o.rdata = head.addr;
        end
      end
      ERR_CODE: begin
        if (!empty) begin
          reg_rsp_o.rdata[`CL_ERR_BITS-1:0] = head.err;
        end
      end
      ERR_STATUS: begin
        reg_rsp_o.rdata[CNT_W-1:0] = count_q;
        reg_rsp_o.rdata[8]         = ovf_q;
      end
      default: reg_rsp_o.rdata = '0;
    endcase
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    count_q <= CNT_W'(DEPTH))
    else $error("bus_err_log: count above depth");

endmodule

/* hdl/core_periph_top.sv */
// Core-local peripheral block with bus error logs, register demux and interrupt vector
`timescale 1ns/1ps
`include "cl_consts.svh"

module core_periph_top (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic [`CL_NUM_IRQS-1:0]       irqs_i,
  input  logic [`CL_NUM_TIMER_IRQS-1:0] timer_irqs_i,
  input  cl_periph_pkg::obi_mon_t       instr_bus_i,
  input  cl_periph_pkg::obi_mon_t       data_bus_i,
  input  cl_periph_pkg::obi_mon_t       shadow_bus_i,
  input  cl_periph_pkg::reg_req_t       reg_req_i,
  output cl_periph_pkg::reg_rsp_t       reg_rsp_o,
  output logic [31:0]                   core_irq_o
);

  import cl_periph_pkg::*;

  // Index 0 instr, 1 data, 2 shadow, as in periph_sel_e
  obi_mon_t [2:0] mon_bus;
  logic     [2:0] trk_err_valid;
  err_rec_t [2:0] trk_err_rec;
  reg_req_t [2:0] unit_req;
  reg_rsp_t [2:0] unit_rsp;
  logic     [2:0] bus_err_irq;

  assign mon_bus = {shadow_bus_i, data_bus_i, instr_bus_i};

  regbus_demux i_regbus_demux (
    .reg_req_i  ( reg_req_i ),
    .reg_rsp_o  ( reg_rsp_o ),
    .unit_req_o ( unit_req  ),
    .unit_rsp_i ( unit_rsp  )
  );

  for (genvar i = 0; i < 3; i++) begin : gen_bus_err
    obi_txn_tracker i_tracker (
      .clk_i       ( clk_i            ),
      .reset_i     ( reset_i          ),
      .bus_i       ( mon_bus[i]       ),
      .err_valid_o ( trk_err_valid[i] ),
      .err_rec_o   ( trk_err_rec[i]   )
    );

    bus_err_log i_log (
      .clk_i       ( clk_i            ),
      .reset_i     ( reset_i          ),
      .err_valid_i ( trk_err_valid[i] ),
      .err_rec_i   ( trk_err_rec[i]   ),
      .reg_req_i   ( unit_req[i]      ),
      .reg_rsp_o   ( unit_rsp[i]      ),
      .err_irq_o   ( bus_err_irq[i]   )
    );
  end

  // CLIC-less forwarding layout, bit 21 (resynch) unused
  always_comb begin
    core_irq_o                               = '0;
    core_irq_o[22 +: `CL_NUM_IRQS]           = irqs_i;
    core_irq_o[20:18]                        = bus_err_irq;
    core_irq_o[16 +: `CL_NUM_TIMER_IRQS]     = timer_irqs_i;
    // mtip
    core_irq_o[7]                            = timer_irqs_i[0];
  end

endmodule

/* tb/tb_core_periph.sv */
// Self-checking testbench for core_periph_top; applies a table of bus, register and interrupt steps
`timescale 1ns/1ps
`include "cl_consts.svh"

module tb_core_periph;

  import cl_periph_pkg::*;

  localparam int READY_TIMEOUT = 16;

  typedef enum logic [2:0] {
    STEP_GRANT, STEP_RESP, STEP_READ, STEP_WRITE, STEP_IRQ
  } step_kind_e;

  // err holds the response code or the expected error bit
  typedef struct packed {
    step_kind_e  kind;
    logic [1:0]  chan;
    logic [31:0] addr;
    logic [31:0] data;
    logic [1:0]  err;
    logic [9:0]  irqs;
    logic [1:0]  tirqs;
  } step_t;

  logic                          clk;
  logic                          reset_i;
  logic [`CL_NUM_IRQS-1:0]       irqs_i;
  logic [`CL_NUM_TIMER_IRQS-1:0] timer_irqs_i;
  obi_mon_t                      mon_bus [3];
  reg_req_t                      reg_req;
  reg_rsp_t                      reg_rsp;
  logic [31:0]                   core_irq;
  step_t                         steps [$];
  logic [31:0]                   lcg_state;

  core_periph_top i_dut (
    .clk_i        ( clk          ),
    .reset_i      ( reset_i      ),
    .irqs_i       ( irqs_i       ),
    .timer_irqs_i ( timer_irqs_i ),
    .instr_bus_i  ( mon_bus[0]   ),
    .data_bus_i   ( mon_bus[1]   ),
    .shadow_bus_i ( mon_bus[2]   ),
    .reg_req_i    ( reg_req      ),
    .reg_rsp_o    ( reg_rsp      ),
    .core_irq_o   ( core_irq     )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state & 32'hFFFF_FFFC;
  endfunction

  function automatic logic [31:0] reg_addr(input int ch, input err_reg_e off);
    logic [31:0] win;
    case (ch)
      0:       win = `CL_PERIPH_BASE + `CL_INSTR_ERR_OFFSET;
      1:       win = `CL_PERIPH_BASE + `CL_DATA_ERR_OFFSET;
      default: win = `CL_PERIPH_BASE + `CL_SHADOW_ERR_OFFSET;
    endcase
    return win + 32'(off);
  endfunction

  // Forwarding layout: ext 31:22, bus errors 20:18, timers 17:16, mtip 7
  function automatic logic [31:0] irq_vector(input logic [9:0] irqs, input logic [1:0] tirqs,
                                             input logic [2:0] berr);
    logic [31:0] v;
    v        = '0;
    v[31:22] = irqs;
    v[20:18] = berr;
    v[17:16] = tirqs;
    v[7]     = tirqs[0];
    return v;
  endfunction

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_rsp(input reg_rsp_t got, input reg_rsp_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: rsp ready %b error %b rdata %h, expected %b %b %h",
               $time, got.ready, got.error, got.rdata, exp.ready, exp.error, exp.rdata);
      abort_run();
    end
  endtask

  task automatic check_irq(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: core_irq_o %h, expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic grant_step(input int ch, input logic [31:0] addr);
    step_t s;
    s      = '0;
    s.kind = STEP_GRANT;
    s.chan = 2'(ch);
    s.addr = addr;
    steps.push_back(s);
  endtask

  task automatic response_step(input int ch, input logic [1:0] code);
    step_t s;
    s      = '0;
    s.kind = STEP_RESP;
    s.chan = 2'(ch);
    s.err  = code;
    steps.push_back(s);
  endtask

  task automatic read_step(input logic [31:0] addr, input logic [31:0] exp, input logic err);
    step_t s;
    s      = '0;
    s.kind = STEP_READ;
    s.addr = addr;
    s.data = exp;
    s.err  = {1'b0, err};
    steps.push_back(s);
  endtask

  task automatic write_step(input logic [31:0] addr, input logic [31:0] wdata);
    step_t s;
    s      = '0;
    s.kind = STEP_WRITE;
    s.addr = addr;
    s.data = wdata;
    steps.push_back(s);
  endtask

  task automatic irq_step(input logic [9:0] irqs, input logic [1:0] tirqs,
                          input logic [2:0] berr);
    step_t s;
    s       = '0;
    s.kind  = STEP_IRQ;
    s.irqs  = irqs;
    s.tirqs = tirqs;
    s.data  = irq_vector(irqs, tirqs, berr);
    steps.push_back(s);
  endtask

  task automatic build_table();
    logic [31:0] a [9];
    logic [31:0] r;
    int          ch;
    int          i;
    // Clean state after reset
    for (ch = 0; ch < 3; ch++) begin
      read_step(reg_addr(ch, ERR_STATUS), 32'h0, 1'b0);
    end
    irq_step(10'h0, 2'b00, 3'b000);
    // One good and one bad response per channel
    for (ch = 0; ch < 3; ch++) begin
      a[0] = lcg_next();
      a[1] = lcg_next();
      grant_step(ch, a[0]);
      response_step(ch, 2'd0);
      grant_step(ch, a[1]);
      response_step(ch, 2'(ch + 1));
      read_step(reg_addr(ch, ERR_STATUS), 32'h1, 1'b0);
      read_step(reg_addr(ch, ERR_ADDR), a[1], 1'b0);
      read_step(reg_addr(ch, ERR_CODE), 32'(ch + 1), 1'b0);
      irq_step(10'h0, 2'b00, 3'(1 << ch));
      write_step(reg_addr(ch, ERR_POP), 32'h0);
      read_step(reg_addr(ch, ERR_STATUS), 32'h0, 1'b0);
    end
    // Two outstanding on data, only the second errs
    for (i = 0; i < 3; i++) begin
      a[i] = lcg_next();
    end
    grant_step(1, a[0]);
    grant_step(1, a[1]);
    response_step(1, 2'd0);
    response_step(1, 2'd1);
    grant_step(1, a[2]);
    response_step(1, 2'd3);
    read_step(reg_addr(1, ERR_STATUS), 32'h2, 1'b0);
    read_step(reg_addr(1, ERR_ADDR), a[1], 1'b0);
    read_step(reg_addr(1, ERR_CODE), 32'h1, 1'b0);
    irq_step(10'h0, 2'b00, 3'b010);
    write_step(reg_addr(1, ERR_POP), 32'h0);
    read_step(reg_addr(1, ERR_ADDR), a[2], 1'b0);
    read_step(reg_addr(1, ERR_CODE), 32'h3, 1'b0);
    write_step(reg_addr(1, ERR_POP), 32'h0);
    read_step(reg_addr(1, ERR_STATUS), 32'h0, 1'b0);
    irq_step(10'h0, 2'b00, 3'b000);
    // Overflow the shadow log, oldest record stays
    for (i = 0; i < 9; i++) begin
      a[i] = lcg_next();
      grant_step(2, a[i]);
      response_step(2, 2'((i % 3) + 1));
    end
    read_step(reg_addr(2, ERR_STATUS), 32'h108, 1'b0);
    read_step(reg_addr(2, ERR_ADDR), a[0], 1'b0);
    read_step(reg_addr(2, ERR_CODE), 32'h1, 1'b0);
    irq_step(10'h0, 2'b00, 3'b100);
    // Unmapped windows
    read_step(`CL_PERIPH_BASE, `CL_ERR_RDATA, 1'b1);
    read_step(`CL_PERIPH_BASE + 32'h1000, `CL_ERR_RDATA, 1'b1);
    for (i = 0; i < 6; i++) begin
      r = lcg_next();
      irq_step(r[31:22], 2'(i), 3'b100);
    end
    irq_step(10'h3FF, 2'b11, 3'b100);
  endtask

  task automatic wait_ready();
    int waited;
    waited = 0;
    #5;
    while (!reg_rsp.ready) begin
      if (waited >= READY_TIMEOUT) begin
        $display("register bus gave no ready within %0d cycles", READY_TIMEOUT);
        abort_run();
      end
      @(negedge clk);
      #5;
      waited++;
    end
  endtask

  task automatic apply_step(input step_t s);
    reg_rsp_t exp;
    @(negedge clk);
    case (s.kind)
      STEP_GRANT, STEP_RESP: begin
        mon_bus[s.chan].req    = (s.kind == STEP_GRANT);
        mon_bus[s.chan].gnt    = (s.kind == STEP_GRANT);
        mon_bus[s.chan].addr   = s.addr;
        mon_bus[s.chan].rvalid = (s.kind == STEP_RESP);
        mon_bus[s.chan].err    = s.err;
        @(negedge clk);
        mon_bus[s.chan] = '0;
      end
      STEP_READ, STEP_WRITE: begin
        reg_req.valid = 1'b1;
        reg_req.write = (s.kind == STEP_WRITE);
        reg_req.addr  = s.addr;
        reg_req.wdata = s.data;
        wait_ready();
        if (s.kind == STEP_READ) begin
          exp.ready = 1'b1;
          exp.error = s.err[0];
          exp.rdata = s.data;
          check_rsp(reg_rsp, exp);
        end
        @(negedge clk);
        reg_req = '0;
      end
      default: begin
        irqs_i       = s.irqs;
        timer_irqs_i = s.tirqs;
        #5;
        check_irq(core_irq, s.data);
      end
    endcase
  endtask

  initial begin
    reset_i      = 1'b1;
    irqs_i       = '0;
    timer_irqs_i = '0;
    reg_req      = '0;
    for (int ch = 0; ch < 3; ch++) begin
      mon_bus[ch] = '0;
    end
    lcg_state = 32'd65;
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+hdl
hdl/cl_periph_pkg.sv
hdl/regbus_demux.sv
hdl/obi_txn_tracker.sv
hdl/bus_err_log.sv
hdl/core_periph_top.sv
tb/tb_core_periph.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_core_periph -f flist.f
out=$(./obj_dir/Vtb_core_periph || true)
echo "$out"
if echo "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
else
  exit 1
fi
